// ==== common/addr_arb_pkg.sv ====
package addr_arb_pkg;

  // ----------------------------------------
  // sizes
  // ----------------------------------------

  localparam int NUM_MASTERS = 4;
  localparam int ID_WIDTH    = 2;   // enough bits to index every master.
  localparam int ADDR_WIDTH  = 32;
  localparam int PROT_WIDTH  = 3;

  // ----------------------------------------
  // vector types
  // ----------------------------------------

  typedef logic [ID_WIDTH-1:0]    master_id_t;
  typedef logic [NUM_MASTERS-1:0] req_vec_t;    // one request level per master.
  typedef logic [ADDR_WIDTH-1:0]  addr_t;
  typedef logic [PROT_WIDTH-1:0]  prot_t;

  // ----------------------------------------
  // bundles
  // ----------------------------------------

  // what a master presents and what the target receives.
  typedef struct packed {
    addr_t addr;
    prot_t prot;
  } addr_req_t;

  // flat width of one address request, used to slice the mux input.
  localparam int ADDR_REQ_WIDTH = $bits(addr_req_t);

  typedef struct packed {
    logic       valid;
    logic       is_write;  // set for a write grant, clear for a read grant.
    master_id_t id;
  } grant_t;

  // ----------------------------------------
  // shared-address FSM
  // ----------------------------------------

  typedef enum logic {
    IDLE,
    GRANT
  } arb_state_e;

endpackage

// ==== hw/mux_enc.sv ====
module mux_enc #(
  parameter int RATIO      = 4,
  parameter int DATA_WIDTH = 1,
  parameter int SEL_WIDTH  = (RATIO > 1) ? $clog2(RATIO) : 1
) (
  input  logic [SEL_WIDTH-1:0]        sel,
  input  logic [RATIO*DATA_WIDTH-1:0] data_in,
  output logic [DATA_WIDTH-1:0]       data_out,
  input  logic                        enable
);

  logic [DATA_WIDTH-1:0] mux_out;

  // each slice is masked by its own decode and ORed onto the running chain.
  function automatic logic [DATA_WIDTH-1:0] f_mux(
    input logic [SEL_WIDTH-1:0]        s,
    input logic [RATIO*DATA_WIDTH-1:0] a
  );
    logic [DATA_WIDTH-1:0] carry;
    carry = {DATA_WIDTH{s == '0}} & a[DATA_WIDTH-1:0];
    for (int i = 1; i < RATIO; i++) begin
      carry = carry | ({DATA_WIDTH{s == SEL_WIDTH'(i)}} & a[i*DATA_WIDTH +: DATA_WIDTH]);
    end
    return carry;
  endfunction

  // ----------------------------------------
  // selection
  // ----------------------------------------

  generate
    if (RATIO < 2) begin : gen_bypass
      assign mux_out = data_in;  // a single input needs no select.
    end else begin : gen_chain
      assign mux_out = f_mux(sel, data_in);
    end
  endgenerate

  assign data_out = mux_out & {DATA_WIDTH{enable}};  // disabled output reads as zero.

endmodule

// ==== hw/addr_arbiter/rr_arbiter.sv ====
module rr_arbiter (
  input  logic                     aclk,
  input  logic                     rst_n,
  input  addr_arb_pkg::req_vec_t   req,
  input  logic                     advance,
  output logic                     req_any,
  output addr_arb_pkg::master_id_t winner
);

  import addr_arb_pkg::*;

  master_id_t last_grant;  // index granted most recently.

  // ----------------------------------------
  // priority scan
  // ----------------------------------------

  // The search starts one past the last grant and wraps around. Walking the
  // offsets from the far end down lets the nearest requester overwrite any
  // farther one, so the final value is the first requester in order.
  always_comb begin
    int idx;
    req_any = 1'b0;
    winner  = last_grant;  // only meaningful while req_any is high.
    idx     = 0;
    for (int off = NUM_MASTERS; off >= 1; off--) begin
      idx = (int'(last_grant) + off) % NUM_MASTERS;
      if (req[idx]) begin
        req_any = 1'b1;
        winner  = master_id_t'(idx);
      end
    end
  end

  // ----------------------------------------
  // pointer
  // ----------------------------------------

  // After reset the pointer sits on the highest index, so master 0 is
  // looked at first.
  always_ff @(posedge aclk) begin
    if (!rst_n) begin
      last_grant <= master_id_t'(NUM_MASTERS - 1);
    end else if (advance) begin
      last_grant <= winner;  // rotate priority past the granted master.
    end
  end

endmodule

// ==== hw/addr_arbiter/sasd_arbiter.sv ====
module sasd_arbiter (
  input  logic                     aclk,
  input  logic                     rst_n,
  input  logic                     rd_any,
  input  logic                     wr_any,
  input  addr_arb_pkg::master_id_t rd_winner,
  input  addr_arb_pkg::master_id_t wr_winner,
  input  logic                     txn_done,
  output logic                     rd_advance,
  output logic                     wr_advance,
  output addr_arb_pkg::grant_t     grant
);

  import addr_arb_pkg::*;

  arb_state_e state;
  arb_state_e state_nxt;
  logic       last_was_write;
  logic       pick_any;
  logic       pick_write;
  logic       take;          // a new grant is latched at the coming edge.
  master_id_t pick_id;

  // ----------------------------------------
  // read or write choice
  // ----------------------------------------

  assign pick_any = rd_any | wr_any;

  // with both kinds pending the kind not granted last time wins.
  assign pick_write = wr_any & (~rd_any | ~last_was_write);

  assign pick_id = pick_write ? wr_winner : rd_winner;

  assign take = (state == IDLE) & pick_any;

  // the round-robin pointers move at the same edge that latches the grant.
  assign rd_advance = take & ~pick_write;
  assign wr_advance = take & pick_write;

  // ----------------------------------------
  // state machine
  // ----------------------------------------

  always_comb begin
    state_nxt = state;
    case (state)
      IDLE: begin
        if (pick_any) begin
          state_nxt = GRANT;
        end
      end
      GRANT: begin
        if (txn_done) begin
          state_nxt = IDLE;  // one empty cycle follows every transfer.
        end
      end
      default: state_nxt = IDLE;
    endcase
  end

  always_ff @(posedge aclk) begin
    if (!rst_n) begin
      state <= IDLE;
    end else begin
      state <= state_nxt;
    end
  end

  // ----------------------------------------
  // grant register
  // ----------------------------------------

  // Reset treats the last kind as write so that reads go first. A done
  // pulse seen in IDLE has no effect on the grant.
  always_ff @(posedge aclk) begin
    if (!rst_n) begin
      grant          <= '0;
      last_was_write <= 1'b1;
    end else if (take) begin
      grant.valid    <= 1'b1;
      grant.is_write <= pick_write;
      grant.id       <= pick_id;
      last_was_write <= pick_write;
    end else if ((state == GRANT) && txn_done) begin
      grant.valid <= 1'b0;  // id and kind are left as they were.
    end
  end

endmodule

// ==== hw/addr_arbiter_top.sv ====
module addr_arbiter_top (
  input  logic                                                  aclk,
  input  logic                                                  rst_n,
  input  addr_arb_pkg::req_vec_t                                rd_req,
  input  addr_arb_pkg::req_vec_t                                wr_req,
  input  addr_arb_pkg::addr_req_t [addr_arb_pkg::NUM_MASTERS-1:0] master_addr,
  input  logic                                                  txn_done,
  output addr_arb_pkg::grant_t                                  grant,
  output addr_arb_pkg::addr_req_t                               target_addr
);

  import addr_arb_pkg::*;

  logic       rd_any;
  logic       wr_any;
  master_id_t rd_winner;
  master_id_t wr_winner;
  logic       rd_advance;
  logic       wr_advance;

  logic [NUM_MASTERS*ADDR_REQ_WIDTH-1:0] addr_flat;  // master 0 in the low bits.
  logic [ADDR_REQ_WIDTH-1:0]             addr_sel;

  // ----------------------------------------
  // request arbitration
  // ----------------------------------------

  rr_arbiter rd_rr (
    .aclk    (aclk),
    .rst_n   (rst_n),
    .req     (rd_req),
    .advance (rd_advance),
    .req_any (rd_any),
    .winner  (rd_winner)
  );

  rr_arbiter wr_rr (
    .aclk    (aclk),
    .rst_n   (rst_n),
    .req     (wr_req),
    .advance (wr_advance),
    .req_any (wr_any),
    .winner  (wr_winner)
  );

  sasd_arbiter sasd (
    .aclk       (aclk),
    .rst_n      (rst_n),
    .rd_any     (rd_any),
    .wr_any     (wr_any),
    .rd_winner  (rd_winner),
    .wr_winner  (wr_winner),
    .txn_done   (txn_done),
    .rd_advance (rd_advance),
    .wr_advance (wr_advance),
    .grant      (grant)
  );

  // ----------------------------------------
  // address path
  // ----------------------------------------

  assign addr_flat = master_addr;

  mux_enc #(
    .RATIO      (NUM_MASTERS),
    .DATA_WIDTH (ADDR_REQ_WIDTH)
  ) addr_mux (
    .sel      (grant.id),
    .data_in  (addr_flat),
    .data_out (addr_sel),
    .enable   (grant.valid)  // no grant, no address.
  );

  assign target_addr = addr_req_t'(addr_sel);

endmodule

// ==== dv/tb_addr_arbiter.sv ====
module tb_addr_arbiter;

  timeunit 1ns;
  timeprecision 100ps;

  import addr_arb_pkg::*;

  // ----------------------------------------
  // stimulus table
  // ----------------------------------------

  localparam int RESET_CYCLES = 5;
  localparam int NUM_ROWS     = 14;

  // rd_set and wr_set are ORed into the held request levels, and the granted
  // master drops its own request in the cycle after done.
  typedef struct packed {
    req_vec_t   rd_set;
    req_vec_t   wr_set;
    logic       exp_write;
    master_id_t exp_id;
    logic [3:0] wait_cycles;  // cycles the grant is held before done.
    logic       idle_done;    // pulse done while idle before the requests.
  } row_t;

  localparam row_t ROWS [NUM_ROWS] = '{
    '{4'b1111, 4'b0000, 1'b0, 2'd0, 4'd0, 1'b0},  // reads rotate from master 0.
    '{4'b0000, 4'b0000, 1'b0, 2'd1, 4'd1, 1'b0},
    '{4'b0000, 4'b0000, 1'b0, 2'd2, 4'd2, 1'b0},
    '{4'b0000, 4'b0000, 1'b0, 2'd3, 4'd0, 1'b0},
    '{4'b0001, 4'b0000, 1'b0, 2'd0, 4'd0, 1'b0},  // wraps back to 0.
    '{4'b0100, 4'b0000, 1'b0, 2'd2, 4'd5, 1'b1},  // lone read with a late done.
    '{4'b1011, 4'b0110, 1'b1, 2'd1, 4'd0, 1'b0},  // last was read, so write.
    '{4'b0000, 4'b0000, 1'b0, 2'd3, 4'd0, 1'b0},
    '{4'b0000, 4'b0000, 1'b1, 2'd2, 4'd3, 1'b0},
    '{4'b0000, 4'b0000, 1'b0, 2'd0, 4'd0, 1'b0},
    '{4'b0000, 4'b1001, 1'b1, 2'd3, 4'd4, 1'b0},
    '{4'b0000, 4'b0000, 1'b0, 2'd1, 4'd0, 1'b0},
    '{4'b0000, 4'b0000, 1'b1, 2'd0, 4'd0, 1'b0},
    '{4'b1000, 4'b0000, 1'b0, 2'd3, 4'd2, 1'b1}
  };

  // ----------------------------------------
  // DUT and clock
  // ----------------------------------------

  logic                              aclk = 1'b0;
  logic                              rst_n;
  req_vec_t                          rd_req;
  req_vec_t                          wr_req;
  addr_req_t [NUM_MASTERS-1:0]       master_addr;
  logic                              txn_done;
  grant_t                            grant;
  addr_req_t                         target_addr;

  integer seed;
  int     checks;
  int     grant_errors;
  int     addr_errors;
  int     flag_errors;

  always #5 aclk = ~aclk;

  addr_arbiter_top UUT (
    .aclk        (aclk),
    .rst_n       (rst_n),
    .rd_req      (rd_req),
    .wr_req      (wr_req),
    .master_addr (master_addr),
    .txn_done    (txn_done),
    .grant       (grant),
    .target_addr (target_addr)
  );

  // ----------------------------------------
  // helpers
  // ----------------------------------------

  // inputs change and outputs are sampled just after the rising edge.
  task automatic step_cycle();
    @(posedge aclk);
    #1;
  endtask

  task automatic check_grant(input string name, input grant_t actual, input grant_t expected);
    checks++;
    if (actual !== expected) begin
      grant_errors++;
      $display("FAILED %0t %s: got %h, expected %h", $time, name, actual, expected);
    end
  endtask

  task automatic check_addr(input string name, input addr_req_t actual,
                            input addr_req_t expected);
    checks++;
    if (actual !== expected) begin
      addr_errors++;
      $display("FAILED %0t %s: got %h, expected %h", $time, name, actual, expected);
    end
  endtask

  task automatic check_flag(input string name, input logic actual, input logic expected);
    checks++;
    if (actual !== expected) begin
      flag_errors++;
      $display("FAILED %0t %s: got %b, expected %b", $time, name, actual, expected);
    end
  endtask

  // every row may take up to its wait plus four cycles.
  function automatic int watchdog_cycles();
    int total;
    total = RESET_CYCLES + 2;
    for (int i = 0; i < NUM_ROWS; i++) begin
      total += int'(ROWS[i].wait_cycles) + 4;
    end
    return total;
  endfunction

  task automatic run_row(input row_t row);
    grant_t    exp_grant;
    addr_req_t exp_addr;
    exp_grant = '{valid: 1'b1, is_write: row.exp_write, id: row.exp_id};
    exp_addr  = master_addr[row.exp_id];
    if (row.idle_done) begin
      txn_done = 1'b1;  // nothing is granted, so this must be ignored.
      step_cycle();
      txn_done = 1'b0;
      check_flag("grant.valid", grant.valid, 1'b0);
      check_addr("target_addr", target_addr, '0);
    end
    rd_req = rd_req | row.rd_set;
    wr_req = wr_req | row.wr_set;
    step_cycle();
    check_grant("grant", grant, exp_grant);
    check_addr("target_addr", target_addr, exp_addr);
    repeat (row.wait_cycles) begin
      step_cycle();
      check_grant("grant", grant, exp_grant);  // must not move while done is late.
      check_addr("target_addr", target_addr, exp_addr);
    end
    txn_done = 1'b1;
    step_cycle();
    txn_done = 1'b0;
    if (row.exp_write) begin
      wr_req[row.exp_id] = 1'b0;
    end else begin
      rd_req[row.exp_id] = 1'b0;
    end
    check_flag("grant.valid", grant.valid, 1'b0);
    check_addr("target_addr", target_addr, '0);
  endtask

  // ----------------------------------------
  // watchdog
  // ----------------------------------------

  initial begin
    repeat (watchdog_cycles()) @(posedge aclk);
    $display("timeout: the run did not finish within %0d cycles", watchdog_cycles());
    $display("*** FAILED ***");
    $finish;
  end

  // ----------------------------------------
  // main sequence
  // ----------------------------------------

  initial begin
    seed         = 32'h3174_a8b5;
    checks       = 0;
    grant_errors = 0;
    addr_errors  = 0;
    flag_errors  = 0;
    rst_n        = 1'b0;
    rd_req       = '0;
    wr_req       = '0;
    txn_done     = 1'b0;
    for (int m = 0; m < NUM_MASTERS; m++) begin
      master_addr[m].addr = addr_t'($random(seed));
      master_addr[m].prot = prot_t'($random(seed));
    end

    repeat (RESET_CYCLES) @(posedge aclk);
    #1;
    rst_n = 1'b1;
    check_flag("grant.valid", grant.valid, 1'b0);
    check_addr("target_addr", target_addr, '0);

    for (int i = 0; i < NUM_ROWS; i++) begin
      run_row(ROWS[i]);
    end

    $display("checks: %0d, grant errors: %0d, address errors: %0d, flag errors: %0d",
             checks, grant_errors, addr_errors, flag_errors);
    if ((grant_errors + addr_errors + flag_errors) == 0) begin
      $display("*** PASSED ***");
    end else begin
      $display("*** FAILED ***");
    end
    $finish;
  end

endmodule

// ==== all.f ====
common/addr_arb_pkg.sv
hw/mux_enc.sv
hw/addr_arbiter/rr_arbiter.sv
hw/addr_arbiter/sasd_arbiter.sv
hw/addr_arbiter_top.sv
dv/tb_addr_arbiter.sv

// ==== Makefile ====
# Verilator build and run for the shared-address arbiter.

VERILATOR  ?= verilator
TOP        ?= tb_addr_arbiter
RTL_TOP    ?= addr_arbiter_top
FILELIST   ?= all.f
BUILD_DIR  ?= obj_dir
LOG        ?= sim.log
VFLAGS     ?= --binary --timing
LINT_FLAGS ?= --lint-only --timing -Wall

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) \
		--Mdir $(BUILD_DIR) -o V$(TOP)

run: build
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@if grep -qF "*** FAILED ***" $(LOG); then \
		echo "simulation reported a failure"; exit 1; \
	fi
	@if ! grep -qF "*** PASSED ***" $(LOG); then \
		echo "simulation ended without a result"; exit 1; \
	fi

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
